// ==== hw/ctrlPkg.sv ====
package ctrlPkg;

  typedef logic [5:0] opcodeT;      // Instruction bits 31:26
  typedef logic [5:0] functT;       // R-type bits 5:0
  typedef logic [3:0] aluOpT;
  typedef logic [3:0] stepT;        // Step index inside one FSM state
  typedef logic [2:0] instrClassT;
  typedef logic [1:0] excVecT;      // Selects the handler address
  typedef logic [1:0] pcSrcT;
  typedef logic [0:0] srcAT;
  typedef logic [1:0] srcBT;

  // Opcodes
  localparam opcodeT opR     = 6'h00;
  localparam opcodeT opAddi  = 6'h08;
  localparam opcodeT opAddiu = 6'h09;
  localparam opcodeT opBeq   = 6'h04;
  localparam opcodeT opBne   = 6'h05;
  localparam opcodeT opLw    = 6'h23;
  localparam opcodeT opSw    = 6'h2B;

  // R-type functs
  localparam functT fnAdd  = 6'h20;
  localparam functT fnAnd  = 6'h24;
  localparam functT fnSub  = 6'h22;
  localparam functT fnSlt  = 6'h2A;
  localparam functT fnMult = 6'h18;
  localparam functT fnDiv  = 6'h1A;

  // ALU operations
  localparam aluOpT aluAdd = 4'd1;
  localparam aluOpT aluSub = 4'd2;
  localparam aluOpT aluAnd = 4'd3;
  localparam aluOpT aluSlt = 4'd10;
  localparam aluOpT aluEq  = 4'd11;  // Sets the datapath condition flag
  localparam aluOpT aluNe  = 4'd12;

  localparam stepT lastStep = 4'd8;  // Longest sequence is load/store

  // Instruction classes
  localparam instrClassT clsAlu     = 3'd0;
  localparam instrClassT clsAluImm  = 3'd1;
  localparam instrClassT clsBranch  = 3'd2;
  localparam instrClassT clsLoad    = 3'd3;
  localparam instrClassT clsStore   = 3'd4;
  localparam instrClassT clsArith   = 3'd5;
  localparam instrClassT clsInvalid = 3'd6;

  // Exception vectors
  localparam excVecT excInvalid  = 2'd0;
  localparam excVecT excOverflow = 2'd1;
  localparam excVecT excDivZero  = 2'd2;

  // PC sources
  localparam pcSrcT pcFromAlu    = 2'd0;  // Branch target
  localparam pcSrcT pcFromAluOut = 2'd1;  // PC+4
  localparam pcSrcT pcFromVector = 2'd2;

  // ALU operand selects
  localparam srcAT srcAPc  = 1'b0;
  localparam srcAT srcAReg = 1'b1;

  localparam srcBT srcBReg    = 2'd0;
  localparam srcBT srcBFour   = 2'd1;
  localparam srcBT srcBImm    = 2'd2;
  localparam srcBT srcBBranch = 2'd3;  // Sign-extended offset shifted by two

endpackage

// ==== hw/stepTimer.sv ====
module stepTimer (
  input  logic          clk,
  input  logic          reset_in,
  input  logic          advance,
  input  logic          clear,
  output ctrlPkg::stepT step
);
  import ctrlPkg::*;

  stepT stepQ;

  always_ff @(posedge clk) begin
    if (reset_in) begin
      stepQ <= '0;
    end else if (clear) begin
      stepQ <= '0;  // Leaving a state
    end else if (advance) begin
      stepQ <= stepQ + 4'd1;
    end
  end

  assign step = stepQ;

  // Sequences restart before running past the load/store length
  stepBounded: assert property (
    @(posedge clk) disable iff (reset_in)
    stepQ <= lastStep
  ) else $error("step counter ran past the last step");

endmodule

// ==== hw/instrDecoder.sv ====
module instrDecoder (
  input  logic                 clk,
  input  logic                 reset_in,
  input  logic                 capture,
  input  ctrlPkg::opcodeT      opcode,
  input  ctrlPkg::functT       funct,
  output ctrlPkg::instrClassT  instrClass,
  output ctrlPkg::aluOpT       execAluOp,
  output logic                 arithIsDiv,
  output logic                 ignoreOverflow
);
  import ctrlPkg::*;

  instrClassT decClass;
  aluOpT      decAluOp;
  logic       decDiv;
  logic       decIgnore;

  instrClassT classQ;
  aluOpT      aluOpQ;
  logic       divQ;
  logic       ignoreQ;

  always_comb begin
    decClass  = clsInvalid;  // Anything not listed below
    decAluOp  = aluAdd;
    decDiv    = 1'b0;
    decIgnore = 1'b0;
    case (opcode)
      opR: begin
        case (funct)
          fnAdd: decClass = clsAlu;
          fnSub: begin
            decClass = clsAlu;
            decAluOp = aluSub;
          end
          fnAnd: begin
            decClass = clsAlu;
            decAluOp = aluAnd;
          end
          fnSlt: begin
            decClass = clsAlu;
            decAluOp = aluSlt;
          end
          fnMult: decClass = clsArith;
          fnDiv: begin
            decClass = clsArith;
            decDiv   = 1'b1;
          end
          default: decClass = clsInvalid;
        endcase
      end
      opAddi: decClass = clsAluImm;
      opAddiu: begin
        decClass  = clsAluImm;
        decIgnore = 1'b1;  // Unsigned add never traps
      end
      opBeq: begin
        decClass = clsBranch;
        decAluOp = aluEq;
      end
      opBne: begin
        decClass = clsBranch;
        decAluOp = aluNe;
      end
      opLw: decClass = clsLoad;
      opSw: decClass = clsStore;
      default: decClass = clsInvalid;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_in) begin
      classQ  <= clsAlu;
      aluOpQ  <= aluAdd;
      divQ    <= 1'b0;
      ignoreQ <= 1'b0;
    end else if (capture) begin
      classQ  <= decClass;
      aluOpQ  <= decAluOp;
      divQ    <= decDiv;
      ignoreQ <= decIgnore;
    end
  end

  // Bypass on the capture cycle so the FSM can branch to execute right away
  assign instrClass     = capture ? decClass : classQ;
  assign execAluOp      = capture ? decAluOp : aluOpQ;
  assign arithIsDiv     = capture ? decDiv : divQ;
  assign ignoreOverflow = capture ? decIgnore : ignoreQ;

endmodule

// ==== hw/excTracker.sv ====
module excTracker (
  input  logic            clk,
  input  logic            reset_in,
  input  logic            overflow,
  input  logic            divZero,
  input  logic            invalidSeen,
  input  logic            ignoreOverflow,
  input  logic            excTaken,
  output logic            excPending,
  output ctrlPkg::excVecT excVector
);
  import ctrlPkg::*;

  logic invalidQ;
  logic overflowQ;
  logic divZeroQ;

  // A new cause in the same cycle as excTaken is still kept
  always_ff @(posedge clk) begin
    if (reset_in) begin
      invalidQ  <= 1'b0;
      overflowQ <= 1'b0;
      divZeroQ  <= 1'b0;
    end else begin
      invalidQ  <= (invalidQ & ~excTaken) | invalidSeen;
      overflowQ <= (overflowQ & ~excTaken) | (overflow & ~ignoreOverflow);  // addiu masks
      divZeroQ  <= (divZeroQ & ~excTaken) | divZero;
    end
  end

  assign excPending = invalidQ | overflowQ | divZeroQ;

  always_comb begin
    if (invalidQ) begin
      excVector = excInvalid;
    end else if (overflowQ) begin
      excVector = excOverflow;
    end else if (divZeroQ) begin
      excVector = excDivZero;
    end else begin
      excVector = excInvalid;  // Don't care when nothing pending
    end
  end

endmodule

// ==== hw/controlFsm.sv ====
module controlFsm (
  input  logic                clk,
  input  logic                reset_in,
  input  ctrlPkg::stepT       step,
  input  ctrlPkg::instrClassT instrClass,
  input  ctrlPkg::aluOpT      execAluOp,
  input  logic                condMet,
  input  logic                arithAck,
  input  logic                excPending,
  output logic                advance,
  output logic                clear,
  output logic                capture,
  output logic                invalidSeen,
  output logic                excTaken,
  output logic                pcWrite,
  output ctrlPkg::pcSrcT      pcSrc,
  output logic                irWrite,
  output logic                aluOutWrite,
  output ctrlPkg::srcAT       aluSrcA,
  output ctrlPkg::srcBT       aluSrcB,
  output ctrlPkg::aluOpT      aluOp,
  output logic                aWrite,
  output logic                bWrite,
  output logic                regWrite,
  output logic                regSrcMem,
  output logic                memAddrSel,
  output logic                memWrite,
  output logic                mdrWrite,
  output logic                hiLoWrite,
  output logic                arithReq,
  output logic                epcWrite
);
  import ctrlPkg::*;

  typedef enum logic [3:0] {
    stReset, stFetch, stAlu, stBranch, stLoad,
    stStore, stArith, stException, stWaitMem
  } stateT;

  stateT state;
  stateT nextState;
  logic  hold;     // Freeze the step while waiting on the arithmetic unit
  logic  isStore;

  always_ff @(posedge clk) begin
    if (reset_in) begin
      state <= stReset;
    end else begin
      state <= nextState;
    end
  end

  assign isStore = (state == stStore);

  always_comb begin
    nextState   = state;
    hold        = 1'b0;
    clear       = 1'b0;
    capture     = 1'b0;
    invalidSeen = 1'b0;
    excTaken    = 1'b0;
    pcWrite     = 1'b0;
    pcSrc       = pcFromAluOut;
    irWrite     = 1'b0;
    aluOutWrite = 1'b0;
    aluSrcA     = srcAPc;
    aluSrcB     = srcBReg;
    aluOp       = aluAdd;
    aWrite      = 1'b0;
    bWrite      = 1'b0;
    regWrite    = 1'b0;
    regSrcMem   = 1'b0;
    memAddrSel  = 1'b0;
    memWrite    = 1'b0;
    mdrWrite    = 1'b0;
    hiLoWrite   = 1'b0;
    arithReq    = 1'b0;
    epcWrite    = 1'b0;
    case (state)
      stReset: begin
        clear     = 1'b1;
        nextState = stFetch;
      end
      stFetch: begin
        case (step)
          4'd0: begin
            if (excPending) begin
              clear     = 1'b1;
              nextState = stException;
            end else begin
              aluSrcB     = srcBFour;  // PC+4 into ALUOut
              aluOutWrite = 1'b1;
            end
          end
          4'd2: irWrite = 1'b1;
          4'd4: begin
            capture = 1'b1;
            pcWrite = 1'b1;
            clear   = 1'b1;
            case (instrClass)
              clsAlu, clsAluImm: nextState = stAlu;
              clsBranch: nextState = stBranch;
              clsLoad: nextState = stLoad;
              clsStore: nextState = stStore;
              clsArith: nextState = stArith;
              default: begin
                invalidSeen = 1'b1;
                nextState   = stException;
              end
            endcase
          end
          default: hold = 1'b0;
        endcase
      end
      stAlu: begin
        aluSrcA = srcAReg;
        aluSrcB = (instrClass == clsAluImm) ? srcBImm : srcBReg;
        if (step != 4'd0) aluOp = execAluOp;
        case (step)
          4'd0: begin
            aWrite = 1'b1;
            bWrite = 1'b1;
          end
          4'd2: regWrite = 1'b1;  // ALU result to rd/rt
          4'd4: begin
            clear     = 1'b1;
            nextState = stFetch;
          end
          default: hold = 1'b0;
        endcase
      end
      stBranch: begin
        case (step)
          4'd0: begin
            aWrite = 1'b1;
            bWrite = 1'b1;
          end
          4'd1: begin
            aluOp   = execAluOp;  // Compare rs with rt
            aluSrcA = srcAReg;
          end
          4'd2: begin
            if (!condMet) begin
              clear     = 1'b1;
              nextState = stFetch;
            end else begin
              aluSrcB = srcBBranch;
            end
          end
          4'd3: begin
            aluSrcB = srcBBranch;
            pcSrc   = pcFromAlu;
            pcWrite = 1'b1;
          end
          default: begin
            clear     = 1'b1;
            nextState = stFetch;
          end
        endcase
      end
      stLoad, stStore: begin
        case (step)
          4'd0: begin
            aWrite = 1'b1;
            bWrite = isStore;  // Store data comes from rt
          end
          4'd1: begin
            aluSrcA     = srcAReg;
            aluSrcB     = srcBImm;
            aluOutWrite = 1'b1;  // Effective address
          end
          4'd2, 4'd3, 4'd5: memAddrSel = 1'b1;
          4'd4: begin
            memAddrSel = 1'b1;
            mdrWrite   = !isStore;
          end
          4'd6: begin
            memAddrSel = isStore;
            memWrite   = isStore;
            regWrite   = !isStore;
            regSrcMem  = !isStore;
          end
          4'd8: begin
            clear     = 1'b1;
            nextState = stWaitMem;
          end
          default: hold = 1'b0;
        endcase
      end
      stArith: begin
        case (step)
          4'd0: begin
            aWrite = 1'b1;
            bWrite = 1'b1;
          end
          4'd1: begin
            arithReq = 1'b1;
            hold     = !arithAck;
          end
          4'd2: hold = arithAck;  // Wait for ack to drop
          default: begin
            hiLoWrite = 1'b1;
            clear     = 1'b1;
            nextState = stFetch;
          end
        endcase
      end
      stException: begin
        pcSrc = pcFromVector;
        case (step)
          4'd0: begin
            aluOp       = aluSub;  // Back up to the faulting instruction
            aluSrcB     = srcBFour;
            aluOutWrite = 1'b1;
          end
          4'd2: begin
            epcWrite = 1'b1;
            pcWrite  = 1'b1;
          end
          4'd4: begin
            excTaken  = 1'b1;
            clear     = 1'b1;
            nextState = stWaitMem;
          end
          default: hold = 1'b0;
        endcase
      end
      stWaitMem: begin
        if (step == 4'd1) begin
          clear     = 1'b1;
          nextState = stFetch;
        end
      end
      default: begin
        clear     = 1'b1;
        nextState = stReset;
      end
    endcase
    advance = !hold;
  end

  // Four-phase handshake toward the arithmetic unit
  reqHeldUntilAck: assert property (
    @(posedge clk) disable iff (reset_in)
    $fell(arithReq) |-> $past(arithAck)
  ) else $error("arithReq dropped before arithAck");

  pcWriteSteps: assert property (
    @(posedge clk) disable iff (reset_in)
    pcWrite |-> (state == stFetch && step == 4'd4) ||
                (state == stBranch && step == 4'd3) ||
                (state == stException && step == 4'd2)
  ) else $error("pcWrite outside its steps");

  // The cause stays latched until excTaken at step 4
  epcWriteStep: assert property (
    @(posedge clk) disable iff (reset_in)
    epcWrite |-> state == stException && step == 4'd2 && excPending
  ) else $error("epcWrite outside exception step 2");

endmodule

// ==== hw/controlUnit.sv ====
module controlUnit (
  input  logic            clk,
  input  logic            reset_in,
  input  ctrlPkg::opcodeT opcode,
  input  ctrlPkg::functT  funct,
  input  logic            condMet,
  input  logic            overflow,
  input  logic            divZero,
  input  logic            arithAck,
  output logic            pcWrite,
  output ctrlPkg::pcSrcT  pcSrc,
  output logic            irWrite,
  output logic            aluOutWrite,
  output ctrlPkg::srcAT   aluSrcA,
  output ctrlPkg::srcBT   aluSrcB,
  output ctrlPkg::aluOpT  aluOp,
  output logic            aWrite,
  output logic            bWrite,
  output logic            regWrite,
  output logic            regSrcMem,
  output logic            memAddrSel,
  output logic            memWrite,
  output logic            mdrWrite,
  output logic            hiLoWrite,
  output logic            arithReq,
  output logic            arithIsDiv,
  output logic            epcWrite,
  output ctrlPkg::excVecT excVector
);
  import ctrlPkg::*;

  stepT       step;
  logic       advance;
  logic       clear;
  logic       capture;
  instrClassT instrClass;
  aluOpT      execAluOp;
  logic       ignoreOverflow;
  logic       invalidSeen;
  logic       excTaken;
  logic       excPending;

  controlFsm uFsm (
    .clk, .reset_in, .step, .instrClass, .execAluOp, .condMet, .arithAck, .excPending,
    .advance, .clear, .capture, .invalidSeen, .excTaken,
    .pcWrite, .pcSrc, .irWrite, .aluOutWrite, .aluSrcA, .aluSrcB, .aluOp,
    .aWrite, .bWrite, .regWrite, .regSrcMem, .memAddrSel, .memWrite, .mdrWrite,
    .hiLoWrite, .arithReq, .epcWrite
  );

  stepTimer uStep (
    .clk, .reset_in, .advance, .clear, .step
  );

  instrDecoder uDecode (
    .clk, .reset_in, .capture, .opcode, .funct,
    .instrClass, .execAluOp, .arithIsDiv, .ignoreOverflow
  );

  excTracker uExc (
    .clk, .reset_in, .overflow, .divZero, .invalidSeen, .ignoreOverflow, .excTaken,
    .excPending, .excVector
  );

endmodule

// ==== tb/controlUnitTb.sv ====
module controlUnitTb;
  timeunit 1ns;
  timeprecision 100ps;
  import ctrlPkg::*;

  localparam int maxWait = 80;  // Cycles any single wait may take

  logic     clk = 1'b0;
  logic     reset_in;
  opcodeT   opcode;
  functT    funct;
  logic     condMet;
  logic     overflow;
  logic     divZero;
  logic     arithAck;
  logic     pcWrite;
  pcSrcT    pcSrc;
  logic     irWrite;
  logic     aluOutWrite;
  srcAT     aluSrcA;
  srcBT     aluSrcB;
  aluOpT    aluOp;
  logic     aWrite;
  logic     bWrite;
  logic     regWrite;
  logic     regSrcMem;
  logic     memAddrSel;
  logic     memWrite;
  logic     mdrWrite;
  logic     hiLoWrite;
  logic     arithReq;
  logic     arithIsDiv;
  logic     epcWrite;
  excVecT   excVector;

  int    checks;
  int    errors;
  int    testErrors;
  string testName;

  // Event counts since the instruction was issued
  int     irCnt;
  int     fetchPcCnt;
  int     branchPcCnt;
  int     regWriteCnt;
  int     memWriteCnt;
  int     addrSelCnt;
  int     epcCnt;
  int     hiLoCnt;
  int     hiLoEarly;
  aluOpT  lastRegAluOp;
  logic   lastRegSrcMem;
  srcAT   lastRegSrcA;
  srcBT   lastRegSrcB;
  excVecT lastExcVec;

  logic [31:0] lfsr = 32'h3d64;

  controlUnit dut (.*);

  always #50 clk = ~clk;

  // Outputs settle well before the falling edge
  always @(negedge clk) begin
    if (!reset_in) begin
      if (irWrite) irCnt++;
      if (pcWrite && pcSrc == pcFromAluOut) fetchPcCnt++;
      if (pcWrite && pcSrc == pcFromAlu) branchPcCnt++;
      if (regWrite) begin
        regWriteCnt++;
        lastRegAluOp  = aluOp;
        lastRegSrcMem = regSrcMem;
        lastRegSrcA   = aluSrcA;
        lastRegSrcB   = aluSrcB;
      end
      if (memWrite) memWriteCnt++;
      if (memAddrSel) addrSelCnt++;
      if (epcWrite) begin
        epcCnt++;
        lastExcVec = excVector;
      end
      if (hiLoWrite) begin
        hiLoCnt++;
        if (arithAck) hiLoEarly++;  // Must wait for ack to drop
      end
    end
  end

  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic takeBits(input int count, output int value);
    value = 0;
    for (int i = 0; i < count; i++) begin
      lfsr  = lfsrStep(lfsr);
      value = (value << 1) | int'(lfsr[0]);
    end
  endtask

  task automatic cycle();
    @(posedge clk);
    #5;
  endtask

  task automatic check(input logic [31:0] expected, input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      $display("ERR %s expected %0h actual %0h", testName, expected, actual);
      errors++;
      testErrors++;
    end
  endtask

  task automatic abortRun(input string what);
    errors++;
    $display("timeout in %s while waiting for %s", testName, what);
    $display("TESTS FAILED");
    $finish;
  endtask

  task automatic beginTest(input string name);
    testName   = name;
    testErrors = 0;
  endtask

  task automatic endTest();
    $display("%s: %s", testName, (testErrors == 0) ? "ok" : "failed");
  endtask

  // Called just after an irWrite, while the IR holds the new word
  task automatic issue(input opcodeT op, input functT fn);
    opcode      = op;
    funct       = fn;
    irCnt       = 0;
    fetchPcCnt  = 0;
    branchPcCnt = 0;
    regWriteCnt = 0;
    memWriteCnt = 0;
    addrSelCnt  = 0;
    epcCnt      = 0;
    hiLoCnt     = 0;
    hiLoEarly   = 0;
  endtask

  task automatic waitNextFetch();
    int n;
    n = 0;
    while (irCnt == 0 && n < maxWait) begin
      cycle();
      n++;
    end
    if (irCnt == 0) abortRun("the next irWrite");
  endtask

  task automatic checkFetch();
    check(1, 32'(irCnt));
    check(1, 32'(fetchPcCnt));
  endtask

  task automatic resetAndFetch();
    int n;
    beginTest("reset and fetch");
    repeat (16) begin
      cycle();
      check(0, 32'({pcWrite, irWrite, aluOutWrite, aWrite, bWrite, regWrite,
                    memAddrSel, memWrite, mdrWrite, hiLoWrite, arithReq, epcWrite}));
    end
    reset_in = 1'b0;
    n = 0;
    while (!irWrite && n < maxWait) begin
      cycle();
      n++;
    end
    if (!irWrite) abortRun("the first irWrite");
    check(3, 32'(n));
    cycle();  // Into fetch step 3
    endTest();
  endtask

  task automatic aluCase(input opcodeT op, input functT fn, input aluOpT expOp);
    issue(op, fn);
    waitNextFetch();
    checkFetch();
    check(1, 32'(regWriteCnt));
    check(32'(expOp), 32'(lastRegAluOp));
    check(0, 32'(lastRegSrcMem));
    check(32'(srcAReg), 32'(lastRegSrcA));
    check(32'((op == opR) ? srcBReg : srcBImm), 32'(lastRegSrcB));
  endtask

  task automatic aluInstructions();
    beginTest("alu");
    aluCase(opR, fnAdd, aluAdd);
    aluCase(opR, fnAnd, aluAnd);
    aluCase(opR, fnSub, aluSub);
    aluCase(opR, fnSlt, aluSlt);
    aluCase(opAddi, 6'h00, aluAdd);
    endTest();
  endtask

  task automatic branchCase(input opcodeT op, input logic taken);
    condMet = taken;
    issue(op, 6'h00);
    waitNextFetch();
    checkFetch();
    check(32'(taken), 32'(branchPcCnt));
    check(0, 32'(regWriteCnt));
    check(0, 32'(memWriteCnt));
    condMet = 1'b0;
  endtask

  task automatic branches();
    beginTest("branch");
    branchCase(opBeq, 1'b1);
    branchCase(opBeq, 1'b0);
    branchCase(opBne, 1'b1);
    branchCase(opBne, 1'b0);
    endTest();
  endtask

  task automatic loadStore();
    beginTest("load store");
    issue(opLw, 6'h00);
    waitNextFetch();
    checkFetch();
    check(1, 32'(regWriteCnt));
    check(1, 32'(lastRegSrcMem));
    check(0, 32'(memWriteCnt));
    check(4, 32'(addrSelCnt));  // Steps 2 to 5
    issue(opSw, 6'h00);
    waitNextFetch();
    checkFetch();
    check(1, 32'(memWriteCnt));
    check(0, 32'(regWriteCnt));
    endTest();
  endtask

  task automatic arithCase(input functT fn, input logic zeroPulse);
    int n;
    int delay;
    issue(opR, fn);
    n = 0;
    while (!arithReq && n < maxWait) begin
      cycle();
      n++;
    end
    if (!arithReq) abortRun("arithReq to rise");
    check(32'(fn == fnDiv), 32'(arithIsDiv));
    takeBits(3, delay);
    repeat (delay) begin
      cycle();
      check(1, 32'(arithReq));
    end
    arithAck = 1'b1;
    divZero  = zeroPulse;
    cycle();
    divZero = 1'b0;
    n = 0;
    while (arithReq && n < maxWait) begin
      cycle();
      n++;
    end
    if (arithReq) abortRun("arithReq to fall");
    check(0, 32'(hiLoCnt));
    arithAck = 1'b0;
    waitNextFetch();
    checkFetch();
    check(1, 32'(hiLoCnt));
    check(0, 32'(hiLoEarly));
    check(32'(zeroPulse), 32'(epcCnt));
    if (zeroPulse) check(32'(excDivZero), 32'(lastExcVec));
  endtask

  task automatic arithHandshake();
    beginTest("arith handshake");
    arithCase(fnMult, 1'b0);
    arithCase(fnDiv, 1'b0);
    arithCase(fnMult, 1'b0);
    arithCase(fnDiv, 1'b0);
    endTest();
  endtask

  task automatic overflowCase(input opcodeT op, input functT fn, input logic trap);
    issue(op, fn);
    cycle();
    cycle();  // Execute step 0
    overflow = 1'b1;
    cycle();
    overflow = 1'b0;
    waitNextFetch();
    checkFetch();
    check(32'(trap), 32'(epcCnt));
    if (trap) check(32'(excOverflow), 32'(lastExcVec));
  endtask

  task automatic exceptions();
    beginTest("exceptions");
    overflowCase(opR, fnAdd, 1'b1);
    overflowCase(opAddiu, 6'h00, 1'b0);
    issue(6'h3F, 6'h00);  // No such opcode
    cycle();
    overflow = 1'b1;  // Invalid outranks an overflow latched alongside it
    cycle();
    overflow = 1'b0;
    waitNextFetch();
    checkFetch();
    check(1, 32'(epcCnt));
    check(32'(excInvalid), 32'(lastExcVec));
    arithCase(fnDiv, 1'b1);
    endTest();
  endtask

  initial begin
    reset_in = 1'b1;
    opcode   = opR;
    funct    = fnAdd;
    condMet  = 1'b0;
    overflow = 1'b0;
    divZero  = 1'b0;
    arithAck = 1'b0;
    checks   = 0;
    errors   = 0;
    resetAndFetch();
    aluInstructions();
    branches();
    loadStore();
    arithHandshake();
    exceptions();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
hw/ctrlPkg.sv
hw/stepTimer.sv
hw/instrDecoder.sv
hw/excTracker.sv
hw/controlFsm.sv
hw/controlUnit.sv
tb/controlUnitTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module controlUnitTb -o simv

out=$(./obj_dir/simv)
echo "$out"

# grep fails the script when the pass line is missing
echo "$out" | grep -q "TESTS PASSED"
